// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - src/mips_isa_pkg.sv
  - src/mips_ctrl_pkg.sv
  - src/core_ifs.sv
  - src/alu.sv
  - src/instr_decoder.sv
  - src/operand_unit.sv
  - src/exec_unit.sv
  - src/mips_core.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/mips_core_tb.sv

// ==== files.f ====
+incdir+sim
src/mips_isa_pkg.sv
src/mips_ctrl_pkg.sv
src/core_ifs.sv
src/alu.sv
src/instr_decoder.sv
src/operand_unit.sv
src/exec_unit.sv
src/mips_core.sv
sim/mips_core_tb.sv

// ==== sim/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_word(input string what, input logic [mips_isa_pkg::XLEN-1:0] got,
		input logic [mips_isa_pkg::XLEN-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

// addresses get their own wording so pc and store address mismatches stand out
task automatic check_addr(input string what, input logic [mips_isa_pkg::XLEN-1:0] got,
		input logic [mips_isa_pkg::XLEN-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at time %0t: %s points to %h, expected %h", $time, what, got,
			exp);
	end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

// plain 32 bit lcg, the state is the returned value
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== sim/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int PROG_CYCLES  = 76; // program words summed over all runs
	localparam int RUNS         = 8;
	localparam int RUN_OVERHEAD = 8; // load and reset cycles of one run
	localparam int MARGIN       = 40;

	logic                          clk;
	logic                          reset;
	logic [mips_isa_pkg::XLEN-1:0] pc;
	logic [mips_isa_pkg::XLEN-1:0] instr;
	logic [mips_isa_pkg::XLEN-1:0] dm_addr;
	logic [mips_isa_pkg::XLEN-1:0] dm_wdata;
	logic                          dm_wen;
	logic [mips_isa_pkg::XLEN-1:0] dm_rdata;

	logic [mips_isa_pkg::XLEN-1:0] rom [64];
	logic [mips_isa_pkg::XLEN-1:0] dmem [256];
	logic [mips_isa_pkg::XLEN-1:0] st_addr [$];
	logic [mips_isa_pkg::XLEN-1:0] st_data [$];
	logic [31:0] rng = 32'h6069;
	int checks = 0;
	int errors = 0;

	`include "tb_checks.svh"

	mips_core dut0 (
		.clk      (clk),
		.reset    (reset),
		.pc       (pc),
		.instr    (instr),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_wen   (dm_wen),
		.dm_rdata (dm_rdata)
	);

	assign instr    = rom[pc[7:2]]; // word addressed fetch
	assign dm_rdata = (dm_addr[31:10] == '0) ? dmem[dm_addr[9:2]] : 'x; // only 1 KiB is backed

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// the memory takes a store on the edge that retires it
	always @(posedge clk) begin
		if (dm_wen && !reset) begin
			dmem[dm_addr[9:2]] <= dm_wdata;
			st_addr.push_back(dm_addr);
			st_data.push_back(dm_wdata);
		end
	end

	function automatic logic [31:0] r_type(input int rs, rt, rd, input logic [5:0] fn);
		return {mips_isa_pkg::OP_R, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, rt,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] j_type(input logic [5:0] op, input int index);
		return {op, 26'(index)};
	endfunction

	// taken bne lands at pc + 4 plus the offset in words
	function automatic logic [31:0] branch_dest(input logic [31:0] at, input logic [15:0] off);
		return at + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	function automatic logic [31:0] jump_dest(input logic [31:0] at, input int index);
		return {at[31:28], 26'(index), 2'b00};
	endfunction

	task automatic load_program(input logic [31:0] prog [$]);
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < 64; i++)
			rom[i] = (i < prog.size()) ? prog[i] : {6'h3f, 26'(i)}; // undefined opcode fill
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'hd0000000 ^ (i * 32'h00010004);
		st_addr.delete();
		st_data.delete();
	endtask

	task automatic release_reset();
		@(posedge clk);
		@(negedge clk);
		check_addr("pc during reset", pc, mips_isa_pkg::RESET_PC);
		check_flag("dm_wen during reset", dm_wen, 1'b0);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_addr("pc after reset", pc, mips_isa_pkg::RESET_PC);
		check_flag("dm_wen after reset", dm_wen, 1'b0);
	endtask

	task automatic run_until(input logic [31:0] halt);
		int n;
		n = 0;
		while (pc !== halt && n < 32) begin
			@(negedge clk);
			n++;
		end
		if (pc !== halt) begin
			errors++;
			$display("pc never reached the halt loop at %h", halt);
		end
	endtask

	task automatic follow_path(input logic [31:0] path [$]);
		for (int i = 0; i < path.size(); i++) begin
			if (i > 0)
				@(negedge clk);
			check_addr("pc", pc, path[i]);
		end
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		if (st_addr.size() == 0) begin
			errors++;
			$display("missing store of %h to address %h", data, addr);
		end else begin
			check_addr("store address", st_addr.pop_front(), addr);
			check_word("store data", st_data.pop_front(), data);
		end
	endtask

	task automatic no_more_stores();
		if (st_addr.size() != 0) begin
			errors++;
			$display("%0d store(s) not expected, first to address %h", st_addr.size(),
				st_addr[0]);
		end
	endtask

	task automatic reset_state();
		logic [31:0] prog [$];
		prog = '{
			r_type(0, 0, 0, mips_isa_pkg::FN_ADD),
			i_type(mips_isa_pkg::OP_SW, 0, 7, 16'h0040),
			i_type(mips_isa_pkg::OP_SW, 0, 31, 16'h0044),
			j_type(mips_isa_pkg::OP_J, 3)
		};
		load_program(prog);
		release_reset();
		run_until(32'd12);
		expect_store(32'h40, 32'd0);
		expect_store(32'h44, 32'd0);
		no_more_stores();
	endtask

	task automatic arithmetic();
		logic [31:0] prog [$];
		logic [31:0] a;
		logic [31:0] b;
		prog = '{
			i_type(mips_isa_pkg::OP_LW, 0, 1, 16'h0200),
			i_type(mips_isa_pkg::OP_LW, 0, 2, 16'h0204),
			r_type(1, 2, 3, mips_isa_pkg::FN_ADD),
			r_type(1, 2, 4, mips_isa_pkg::FN_SUB),
			r_type(1, 2, 5, mips_isa_pkg::FN_SLT),
			r_type(2, 1, 6, mips_isa_pkg::FN_SLT),
			i_type(mips_isa_pkg::OP_SW, 0, 3, 16'h0300),
			i_type(mips_isa_pkg::OP_SW, 0, 4, 16'h0304),
			i_type(mips_isa_pkg::OP_SW, 0, 5, 16'h0308),
			i_type(mips_isa_pkg::OP_SW, 0, 6, 16'h030c),
			j_type(mips_isa_pkg::OP_J, 10)
		};
		for (int k = 0; k < 3; k++) begin
			rng = lcg_next(rng);
			a = rng;
			rng = lcg_next(rng);
			b = rng;
			load_program(prog);
			dmem['h200 / 4] = a;
			dmem['h204 / 4] = b;
			release_reset();
			run_until(32'd40);
			expect_store(32'h300, a + b);
			expect_store(32'h304, a - b);
			expect_store(32'h308, {31'd0, $signed(a) < $signed(b)});
			expect_store(32'h30c, {31'd0, $signed(b) < $signed(a)});
			no_more_stores();
		end
	endtask

	task automatic xori_and_offsets();
		logic [31:0] prog [$];
		logic [31:0] v;
		logic [31:0] w;
		prog = '{
			i_type(mips_isa_pkg::OP_LW, 0, 1, 16'h0200),
			i_type(mips_isa_pkg::OP_XORI, 1, 2, 16'h8001),
			i_type(mips_isa_pkg::OP_XORI, 0, 3, 16'hffff),
			i_type(mips_isa_pkg::OP_XORI, 0, 5, 16'h0280),
			i_type(mips_isa_pkg::OP_LW, 5, 6, 16'hfff8),
			i_type(mips_isa_pkg::OP_SW, 5, 2, 16'hfffc),
			i_type(mips_isa_pkg::OP_SW, 5, 3, 16'hffc0),
			i_type(mips_isa_pkg::OP_SW, 5, 6, 16'h0000),
			j_type(mips_isa_pkg::OP_J, 8)
		};
		rng = lcg_next(rng);
		v = rng;
		rng = lcg_next(rng);
		w = rng;
		load_program(prog);
		dmem['h200 / 4] = v;
		dmem['h278 / 4] = w;
		release_reset();
		run_until(32'd32);
		expect_store(32'h280 - 32'd4, v ^ 32'h0000_8001); // upper half passes through xori
		expect_store(32'h280 - 32'h40, 32'h0000_ffff);
		expect_store(32'h280, w);
		no_more_stores();
	endtask

	task automatic bne_branches();
		logic [31:0] prog [$];
		logic [31:0] path [$];
		prog = '{
			i_type(mips_isa_pkg::OP_XORI, 0, 1, 16'd5),
			i_type(mips_isa_pkg::OP_XORI, 0, 2, 16'd5),
			i_type(mips_isa_pkg::OP_XORI, 0, 3, 16'd9),
			i_type(mips_isa_pkg::OP_BNE, 1, 2, 16'd4),
			i_type(mips_isa_pkg::OP_SW, 0, 1, 16'h0100),
			i_type(mips_isa_pkg::OP_BNE, 1, 3, 16'd2),
			i_type(mips_isa_pkg::OP_SW, 0, 3, 16'h0104),
			i_type(mips_isa_pkg::OP_SW, 0, 3, 16'h0108),
			i_type(mips_isa_pkg::OP_SW, 0, 3, 16'h010c),
			j_type(mips_isa_pkg::OP_J, 12),
			i_type(mips_isa_pkg::OP_SW, 0, 2, 16'h0110),
			j_type(mips_isa_pkg::OP_J, 14),
			i_type(mips_isa_pkg::OP_BNE, 1, 3, 16'hfffd),
			i_type(mips_isa_pkg::OP_SW, 0, 3, 16'h0114),
			j_type(mips_isa_pkg::OP_J, 14)
		};
		path = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, branch_dest(20, 16'd2), 32'd36,
			jump_dest(36, 12), branch_dest(48, 16'hfffd), 32'd44, jump_dest(44, 14)};
		load_program(prog);
		release_reset();
		follow_path(path);
		expect_store(32'h100, 32'd5);
		expect_store(32'h10c, 32'd9);
		expect_store(32'h110, 32'd5);
		no_more_stores();
	endtask

	task automatic jumps_and_links();
		logic [31:0] prog [$];
		logic [31:0] path [$];
		prog = '{
			i_type(mips_isa_pkg::OP_XORI, 0, 2, 16'h0077),
			j_type(mips_isa_pkg::OP_JAL, 4),
			i_type(mips_isa_pkg::OP_SW, 0, 2, 16'h0124),
			j_type(mips_isa_pkg::OP_J, 8),
			i_type(mips_isa_pkg::OP_SW, 0, 31, 16'h0120),
			r_type(31, 0, 0, mips_isa_pkg::FN_JR),
			i_type(mips_isa_pkg::OP_SW, 0, 2, 16'h0128),
			i_type(mips_isa_pkg::OP_SW, 0, 2, 16'h012c),
			j_type(mips_isa_pkg::OP_J, 8)
		};
		// jr returns to the link value, the word after the jal
		path = '{32'd0, 32'd4, jump_dest(4, 4), 32'd20, 32'd4 + 32'd4, 32'd12, jump_dest(12, 8)};
		load_program(prog);
		release_reset();
		follow_path(path);
		expect_store(32'h120, 32'd4 + 32'd4);
		expect_store(32'h124, 32'h77);
		no_more_stores();
	endtask

	task automatic zero_reg_and_unknown();
		logic [31:0] prog [$];
		logic [31:0] path [$];
		prog = '{
			i_type(mips_isa_pkg::OP_XORI, 0, 1, 16'h1234),
			r_type(1, 1, 0, mips_isa_pkg::FN_ADD),
			i_type(mips_isa_pkg::OP_SW, 0, 0, 16'h0140),
			{6'h3f, 5'd1, 5'd1, 16'hffff}, // would clobber r1 if it did anything
			i_type(mips_isa_pkg::OP_SW, 0, 1, 16'h0144),
			j_type(mips_isa_pkg::OP_J, 5)
		};
		path = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20};
		load_program(prog);
		release_reset();
		follow_path(path);
		expect_store(32'h140, 32'd0);
		expect_store(32'h144, 32'h1234);
		no_more_stores();
	endtask

	initial begin
		#((PROG_CYCLES + RUNS * RUN_OVERHEAD + MARGIN) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	initial begin
		reset = 1'b1;
		reset_state();
		arithmetic();
		xori_and_offsets();
		bne_branches();
		jumps_and_links();
		zero_reg_and_unknown();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  mips_ctrl_pkg::alu_op_e        op,
	input  logic [mips_isa_pkg::XLEN-1:0] a,
	input  logic [mips_isa_pkg::XLEN-1:0] b,
	output logic [mips_isa_pkg::XLEN-1:0] y,
	output logic                          zero
);

	logic signed_lt;

	assign signed_lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_ctrl_pkg::ALU_ADD: y = a + b;
			mips_ctrl_pkg::ALU_SUB: y = a - b;
			mips_ctrl_pkg::ALU_SLT: y = {{(mips_isa_pkg::XLEN-1){1'b0}}, signed_lt};
			mips_ctrl_pkg::ALU_XOR: y = a ^ b;
			default: y = a + b;
		endcase
	end

	// bne only cares whether rs - rt came out as zero
	assign zero = (y == '0);

endmodule

// ==== src/core_ifs.sv ====
`timescale 1ns/1ps

// control word from the decoder to the units that act on it
interface ctrl_if;

	mips_ctrl_pkg::ctrl_word_t cw;

	// the register file only looks at these three fields
	logic imm_signed;
	logic rf_wen;
	mips_ctrl_pkg::wadr_sel_e wadr_sel;

	assign imm_signed = cw.imm_signed;
	assign rf_wen     = cw.rf_wen;
	assign wadr_sel   = cw.wadr_sel;

	modport src (output cw);
	modport dst (input cw);
	modport rf (input imm_signed, input rf_wen, input wadr_sel);

endinterface

// operands out of the register file and the write-back value going in
interface operand_if;

	logic [mips_isa_pkg::XLEN-1:0] rs_val;
	logic [mips_isa_pkg::XLEN-1:0] rt_val;
	logic [mips_isa_pkg::XLEN-1:0] imm_ext;
	logic [mips_isa_pkg::XLEN-1:0] wdata;

	modport src (
		output rs_val,
		output rt_val,
		output imm_ext,
		input  wdata
	);

	modport dst (
		input  rs_val,
		input  rt_val,
		input  imm_ext,
		output wdata
	);

endinterface

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [mips_isa_pkg::XLEN-1:0] instr,
	ctrl_if.dst                           ctrl,
	operand_if.dst                        ops,
	output logic [mips_isa_pkg::XLEN-1:0] pc,
	output logic [mips_isa_pkg::XLEN-1:0] dm_addr,
	output logic [mips_isa_pkg::XLEN-1:0] dm_wdata,
	output logic                          dm_wen,
	input  logic [mips_isa_pkg::XLEN-1:0] dm_rdata
);

	localparam int UPPER_W = mips_isa_pkg::XLEN - mips_isa_pkg::TARGET_W - 2;

	logic [mips_isa_pkg::XLEN-1:0]     alu_b;
	logic [mips_isa_pkg::XLEN-1:0]     alu_y;
	logic                              alu_zero;
	logic [mips_isa_pkg::XLEN-1:0]     pc_plus4;
	logic [mips_isa_pkg::XLEN-1:0]     branch_target;
	logic [mips_isa_pkg::XLEN-1:0]     jump_target;
	logic [mips_isa_pkg::TARGET_W-1:0] target;
	logic                              branch_taken;
	logic [mips_isa_pkg::XLEN-1:0]     pc_next;

	assign alu_b = ctrl.cw.b_from_imm ? ops.imm_ext : ops.rt_val;

	alu u_alu (
		.op   (ctrl.cw.alu_op),
		.a    (ops.rs_val),
		.b    (alu_b),
		.y    (alu_y),
		.zero (alu_zero)
	);

	// data memory sees the effective address straight from the alu
	assign dm_addr  = alu_y;
	assign dm_wdata = ops.rt_val;
	assign dm_wen   = ctrl.cw.dm_wen;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {ops.imm_ext[mips_isa_pkg::XLEN-3:0], 2'b00};
	assign target        = instr[mips_isa_pkg::TARGET_LSB +: mips_isa_pkg::TARGET_W];
	assign jump_target   = {pc[mips_isa_pkg::XLEN-1 -: UPPER_W], target, 2'b00};
	assign branch_taken  = ctrl.cw.is_bne && !alu_zero; // rs != rt

	always_comb begin
		pc_next = pc_plus4;
		case (ctrl.cw.pc_sel)
			mips_ctrl_pkg::PC_SEQ:    pc_next = pc_plus4;
			mips_ctrl_pkg::PC_REG:    pc_next = ops.rs_val;
			mips_ctrl_pkg::PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus4;
			mips_ctrl_pkg::PC_JUMP:   pc_next = jump_target;
			default: pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= mips_isa_pkg::RESET_PC;
		else
			pc <= pc_next; // one instruction retires per edge
	end

	always_comb begin
		case (ctrl.cw.wdata_sel)
			mips_ctrl_pkg::WD_LINK: ops.wdata = pc_plus4;
			mips_ctrl_pkg::WD_MEM:  ops.wdata = dm_rdata;
			mips_ctrl_pkg::WD_ALU:  ops.wdata = alu_y;
			default: ops.wdata = alu_y;
		endcase
	end

	// a jr through a misaligned register would break this
	pc_aligned: assert property (
		@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00
	) else $error("pc lost word alignment: %h", pc);

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	input  logic [mips_isa_pkg::XLEN-1:0] instr,
	ctrl_if.src                           ctrl
);

	logic [mips_isa_pkg::OPCODE_W-1:0] opcode;
	logic [mips_isa_pkg::FUNCT_W-1:0]  funct;
	mips_ctrl_pkg::ctrl_word_t         cw;

	assign opcode = instr[mips_isa_pkg::OPCODE_LSB +: mips_isa_pkg::OPCODE_W];
	assign funct  = instr[mips_isa_pkg::FUNCT_LSB +: mips_isa_pkg::FUNCT_W];

	always_comb begin
		cw = mips_ctrl_pkg::CTRL_NOP; // anything not listed below falls through as a nop
		case (opcode)
			mips_isa_pkg::OP_R: begin
				case (funct)
					mips_isa_pkg::FN_ADD: begin
						cw.alu_op    = mips_ctrl_pkg::ALU_ADD;
						cw.rf_wen    = 1'b1;
						cw.wadr_sel  = mips_ctrl_pkg::WADR_RD;
						cw.wdata_sel = mips_ctrl_pkg::WD_ALU;
					end
					mips_isa_pkg::FN_SUB: begin
						cw.alu_op    = mips_ctrl_pkg::ALU_SUB;
						cw.rf_wen    = 1'b1;
						cw.wadr_sel  = mips_ctrl_pkg::WADR_RD;
						cw.wdata_sel = mips_ctrl_pkg::WD_ALU;
					end
					mips_isa_pkg::FN_SLT: begin
						cw.alu_op    = mips_ctrl_pkg::ALU_SLT;
						cw.rf_wen    = 1'b1;
						cw.wadr_sel  = mips_ctrl_pkg::WADR_RD;
						cw.wdata_sel = mips_ctrl_pkg::WD_ALU;
					end
					mips_isa_pkg::FN_JR: cw.pc_sel = mips_ctrl_pkg::PC_REG;
					default: cw = mips_ctrl_pkg::CTRL_NOP;
				endcase
			end
			mips_isa_pkg::OP_LW: begin
				cw.imm_signed = 1'b1;
				cw.b_from_imm = 1'b1;
				cw.alu_op     = mips_ctrl_pkg::ALU_ADD; // base plus offset
				cw.rf_wen     = 1'b1;
				cw.wadr_sel   = mips_ctrl_pkg::WADR_RT;
				cw.wdata_sel  = mips_ctrl_pkg::WD_MEM;
			end
			mips_isa_pkg::OP_SW: begin
				cw.imm_signed = 1'b1;
				cw.b_from_imm = 1'b1;
				cw.alu_op     = mips_ctrl_pkg::ALU_ADD;
				cw.dm_wen     = 1'b1;
			end
			mips_isa_pkg::OP_J: cw.pc_sel = mips_ctrl_pkg::PC_JUMP;
			mips_isa_pkg::OP_JAL: begin
				cw.pc_sel    = mips_ctrl_pkg::PC_JUMP;
				cw.rf_wen    = 1'b1;
				cw.wadr_sel  = mips_ctrl_pkg::WADR_RA;
				cw.wdata_sel = mips_ctrl_pkg::WD_LINK;
			end
			mips_isa_pkg::OP_BNE: begin
				// rs minus rt feeds the zero flag, the offset is sign extended
				cw.pc_sel     = mips_ctrl_pkg::PC_BRANCH;
				cw.imm_signed = 1'b1;
				cw.alu_op     = mips_ctrl_pkg::ALU_SUB;
				cw.is_bne     = 1'b1;
			end
			mips_isa_pkg::OP_XORI: begin
				cw.b_from_imm = 1'b1; // imm_signed stays low, so zero extension
				cw.alu_op     = mips_ctrl_pkg::ALU_XOR;
				cw.rf_wen     = 1'b1;
				cw.wadr_sel   = mips_ctrl_pkg::WADR_RT;
				cw.wdata_sel  = mips_ctrl_pkg::WD_ALU;
			end
			default: cw = mips_ctrl_pkg::CTRL_NOP;
		endcase
	end

	assign ctrl.cw = cw;

	// a store never writes back into the register file
	dm_rf_excl: assert final (!(ctrl.cw.dm_wen && ctrl.cw.rf_wen))
		else $error("decoder raised dm_wen and rf_wen together");

endmodule

// ==== src/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
	input  logic                          clk,
	input  logic                          reset,
	output logic [mips_isa_pkg::XLEN-1:0] pc,
	input  logic [mips_isa_pkg::XLEN-1:0] instr,
	output logic [mips_isa_pkg::XLEN-1:0] dm_addr,
	output logic [mips_isa_pkg::XLEN-1:0] dm_wdata,
	output logic                          dm_wen,
	input  logic [mips_isa_pkg::XLEN-1:0] dm_rdata
);

	ctrl_if    ctrl_bus ();
	operand_if ops_bus ();

	// decoder and operand unit both work on the same instruction word
	instr_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl_bus.src)
	);

	operand_unit u_operands (
		.clk   (clk),
		.reset (reset),
		.instr (instr),
		.ctrl  (ctrl_bus.rf),
		.ops   (ops_bus.src)
	);

	exec_unit u_exec (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.ctrl     (ctrl_bus.dst),
		.ops      (ops_bus.dst),
		.pc       (pc),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_wen   (dm_wen),
		.dm_rdata (dm_rdata)
	);

endmodule

// ==== src/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

	// where the next pc comes from
	typedef enum logic [1:0] {
		PC_SEQ    = 2'b00,
		PC_REG    = 2'b01, // jr target taken from rs
		PC_BRANCH = 2'b10,
		PC_JUMP   = 2'b11
	} pc_sel_e;

	// register file write address
	typedef enum logic [1:0] {
		WADR_RT = 2'b00,
		WADR_RD = 2'b01,
		WADR_RA = 2'b10
	} wadr_sel_e;

	// register file write data
	typedef enum logic [1:0] {
		WD_LINK = 2'b00, // pc + 4
		WD_MEM  = 2'b01,
		WD_ALU  = 2'b10
	} wdata_sel_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_SLT = 2'b10,
		ALU_XOR = 2'b11
	} alu_op_e;

	typedef struct packed {
		pc_sel_e    pc_sel;
		logic       imm_signed;
		logic       b_from_imm;
		alu_op_e    alu_op;
		logic       dm_wen;
		logic       rf_wen;
		wadr_sel_e  wadr_sel;
		wdata_sel_e wdata_sel;
		logic       is_bne;
	} ctrl_word_t;

	// an instruction that only advances the pc
	localparam ctrl_word_t CTRL_NOP = '{
		pc_sel: PC_SEQ, imm_signed: 1'b0, b_from_imm: 1'b0, alu_op: ALU_ADD,
		dm_wen: 1'b0, rf_wen: 1'b0, wadr_sel: WADR_RT, wdata_sel: WD_ALU,
		is_bne: 1'b0
	};

endpackage

// ==== src/mips_isa_pkg.sv ====
package mips_isa_pkg;

	// word and register file geometry
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;

	localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31; // link register for jal
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// instruction field positions
	localparam int OPCODE_LSB = 26;
	localparam int OPCODE_W   = 6;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int IMM_LSB    = 0;
	localparam int IMM_W      = 16;
	localparam int FUNCT_LSB  = 0;
	localparam int FUNCT_W    = 6;
	localparam int TARGET_LSB = 0;
	localparam int TARGET_W   = 26;

	// primary opcodes
	localparam logic [OPCODE_W-1:0] OP_R    = 6'h00;
	localparam logic [OPCODE_W-1:0] OP_J    = 6'h02;
	localparam logic [OPCODE_W-1:0] OP_JAL  = 6'h03;
	localparam logic [OPCODE_W-1:0] OP_BNE  = 6'h05;
	localparam logic [OPCODE_W-1:0] OP_XORI = 6'h0e;
	localparam logic [OPCODE_W-1:0] OP_LW   = 6'h23;
	localparam logic [OPCODE_W-1:0] OP_SW   = 6'h2b;

	// funct codes, only meaningful with OP_R
	localparam logic [FUNCT_W-1:0] FN_JR  = 6'h08;
	localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2a;

endpackage

// ==== src/operand_unit.sv ====
`timescale 1ns/1ps

module operand_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [mips_isa_pkg::XLEN-1:0] instr,
	ctrl_if.rf                            ctrl,
	operand_if.src                        ops
);

	localparam int EXT_W = mips_isa_pkg::XLEN - mips_isa_pkg::IMM_W;

	logic [mips_isa_pkg::XLEN-1:0]       regs [mips_isa_pkg::NUM_REGS];
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rs;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rt;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] waddr;
	logic [mips_isa_pkg::IMM_W-1:0]      imm;

	assign rs  = instr[mips_isa_pkg::RS_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign rt  = instr[mips_isa_pkg::RT_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign rd  = instr[mips_isa_pkg::RD_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign imm = instr[mips_isa_pkg::IMM_LSB +: mips_isa_pkg::IMM_W];

	// read ports are plain array lookups, register 0 stays at its reset value
	assign ops.rs_val = regs[rs];
	assign ops.rt_val = regs[rt];

	always_comb begin
		if (ctrl.imm_signed)
			ops.imm_ext = {{EXT_W{imm[mips_isa_pkg::IMM_W-1]}}, imm};
		else
			ops.imm_ext = {{EXT_W{1'b0}}, imm};
	end

	always_comb begin
		waddr = rt;
		case (ctrl.wadr_sel)
			mips_ctrl_pkg::WADR_RD: waddr = rd;
			mips_ctrl_pkg::WADR_RA: waddr = mips_isa_pkg::RA_REG;
			default: waddr = rt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < mips_isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (ctrl.rf_wen && waddr != '0) begin
			regs[waddr] <= ops.wdata; // lands at the end of the cycle
		end
	end

	// writes aimed at register 0 must leave it at zero afterwards
	r0_stays_zero: assert property (
		@(posedge clk) disable iff (reset)
		ctrl.rf_wen && waddr == '0 |=> regs[0] == '0
	) else $error("register 0 changed by a write");

endmodule
